/* testbench/boot_cases.txt */
// core port cases, hex, one per line: kind addr data expected
// kind 0 dm read, 1 store then read, 2 window write then read, 3 fetch, ffffffff ends
0 00001000 00000000 00000000
0 0000103c 00000000 00000000
0 00002148 00000000 00000000
0 00004170 00000000 00000000
0 00000100 00000000 00000000
0 0000013c 00000000 00000000
3 00000000 00000000 00000000
3 00000044 00000000 00000000
3 00000400 00000000 00000000
3 00000bfc 00000000 00000000
1 00002000 deadbeef deadbeef
0 00002004 00000000 00000000
0 00002000 00000000 00000000
1 00008ffc 12345678 12345678
1 00005000 a5a55a5a a5a55a5a
2 00009000 cafef00d xxxxxxxx
2 0000fffc 0badf00d xxxxxxxx
0 00001000 00000000 00000000
ffffffff 00000000 00000000 00000000

/* boot_loader.f */
+incdir+rtl
rtl/boot_pkg.sv
rtl/block_ctl_if.sv
rtl/fill_if.sv
rtl/boot_fsm.sv
rtl/block_counter.sv
rtl/data_mem.sv
rtl/instr_mem.sv
rtl/boot_loader.sv
testbench/boot_loader_assertions.sv
testbench/boot_loader_tb.sv

/* testbench/boot_loader_tb.sv */
`include "boot_defines.svh"

module boot_loader_tb;
    import boot_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int DRIVE_DLY  = 10;     // after the rising edge
    localparam int SETTLE     = 20;     // outputs that follow inputs in the same cycle
    localparam int MAX_CASES  = 32;

    // data block bases in the order the host is asked for them
    localparam mem_addr_t DM_ORDER [`DM_BLOCKS] = '{
        16'h1000, 16'h1040, 16'h1100, 16'h1140, 16'h2000, 16'h2040,
        16'h2100, 16'h2140, 16'h3000, 16'h3040, 16'h3100, 16'h3140,
        16'h4000, 16'h4040, 16'h4100, 16'h4140, 16'h0100
    };

    logic        clk;
    logic        rst_n;
    logic        ready;
    logic        rd_valid;
    logic        tx_done;
    logic        core_wrt_en;
    logic        core_rd_en;
    word_t       host_rd_data;
    word_t       host_wrt_data;
    word_t       core_wrt_data;
    word_t       core_rd_data;
    word_t       fetch_instr;
    mem_addr_t   core_addr;
    mem_addr_t   fetch_addr;
    host_op_t    host_op;
    host_addr_t  host_addr;
    logic        core_stall;

    word_t       dm_model [`DM_DEPTH];     // fill words by word index
    word_t       im_model [`IM_DEPTH];
    logic [31:0] cases [4*MAX_CASES];      // kind, addr, data, expected
    int          num_cases;
    int          cycle_count;
    int          cycle_limit;

    boot_loader i_boot_loader (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("timeout: run still going after %0d cycles", cycle_count);
            fail_run();
        end
        if (i_boot_loader.i_boot_fsm.i_boot_loader_assertions.error_count != 0) begin
            $display("a host handshake assertion failed");
            fail_run();
        end
    end

    ////////////////////
    // checking
    task automatic fail_run();
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic compare_value(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
            fail_run();
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    ////////////////////
    // host model
    // word 0 goes with rd_valid, word 15 with tx_done
    task automatic serve_block(input host_addr_t expected_addr, input bit is_im);
        int    base_idx;
        word_t w;
        while (host_op !== host_read)
            next_cycle();
        compare_value("boot read address", expected_addr, host_addr);
        compare_value("stall during boot", 1, core_stall);
        base_idx = expected_addr[15:0] >> 2;
        for (int k = 0; k < `BLOCK_WORDS; k++) begin
            w = $urandom;
            if (is_im)
                im_model[base_idx + k] = w;
            else
                dm_model[base_idx + k] = w;
            rd_valid     = (k == 0);
            tx_done      = (k == `BLOCK_WORDS - 1);
            host_rd_data = w;
            next_cycle();
        end
        rd_valid = 1'b0;
        tx_done  = 1'b0;
    endtask

    ////////////////////
    // core and fetch side
    task automatic core_read(input mem_addr_t addr, input word_t expected);
        core_addr  = addr;
        core_rd_en = 1'b1;
        next_cycle();
        core_rd_en = 1'b0;
        compare_value($sformatf("core read %h", addr), expected, core_rd_data);
    endtask

    task automatic core_write(input mem_addr_t addr, input word_t data);
        core_addr     = addr;
        core_wrt_data = data;
        core_wrt_en   = 1'b1;
        #SETTLE;
        compare_value($sformatf("local write %h stall", addr), 0, core_stall);
        next_cycle();
        core_wrt_en = 1'b0;
    endtask

    task automatic window_write(input mem_addr_t addr, input word_t data);
        string name;
        name          = $sformatf("window write %h", addr);
        core_addr     = addr;
        core_wrt_data = data;
        core_wrt_en   = 1'b1;
        #SETTLE;
        compare_value({name, " op"}, host_write, host_op);
        compare_value({name, " addr"}, {48'h0, addr}, host_addr);
        compare_value({name, " data"}, data, host_wrt_data);
        for (int k = 0; k < 3; k++) begin
            compare_value({name, " stall"}, 1, core_stall);  // host still busy
            next_cycle();
        end
        tx_done = 1'b1;
        #SETTLE;
        compare_value({name, " release"}, 0, core_stall);
        next_cycle();
        tx_done     = 1'b0;
        core_wrt_en = 1'b0;
    endtask

    task automatic fetch_check(input mem_addr_t addr, input word_t expected);
        fetch_addr = addr;
        next_cycle();
        compare_value($sformatf("fetch %h", addr), expected, fetch_instr);
    endtask

    ////////////////////
    // main sequence
    initial begin
        logic [31:0] kind;
        mem_addr_t   addr;
        word_t       data;
        word_t       expected;
        cycle_count   = 0;
        cycle_limit   = 100000;
        rst_n         = 1'b0;
        ready         = 1'b0;
        rd_valid      = 1'b0;
        tx_done       = 1'b0;
        host_rd_data  = '0;
        core_addr     = '0;
        core_wrt_data = '0;
        core_wrt_en   = 1'b0;
        core_rd_en    = 1'b0;
        fetch_addr    = '0;
        void'($urandom(32'hcbb3_a056));

        $readmemh("testbench/boot_cases.txt", cases);
        if (cases[0] === 'x) begin
            $display("could not read any case from testbench/boot_cases.txt");
            fail_run();
        end
        num_cases = 0;
        while (num_cases < MAX_CASES && cases[4*num_cases] !== 32'hffff_ffff)
            num_cases++;
        // 65 blocks of 17 cycles, reset, and up to 8 cycles per case
        cycle_limit = 2 * ((`DM_BLOCKS + `IM_BLOCKS) * 17 + 20 + 8 * num_cases) + 100;

        repeat (10) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;
        repeat (3) begin
            next_cycle();
            compare_value("host_op before ready", host_idle, host_op);
            compare_value("stall before ready", 1, core_stall);
        end
        ready = 1'b1;
        next_cycle();
        ready = 1'b0;

        for (int b = 0; b < `DM_BLOCKS; b++)
            serve_block({48'h0, DM_ORDER[b]}, 1'b0);
        for (int b = 0; b < `IM_BLOCKS; b++)
            serve_block({47'h0, 1'b1, 16'(b * 64)}, 1'b1);  // bit 16 marks IM
        compare_value("stall after boot", 0, core_stall);

        for (int i = 0; i < num_cases; i++) begin
            kind     = cases[4*i];
            addr     = cases[4*i+1];
            data     = cases[4*i+2];
            expected = cases[4*i+3];
            case (kind)
                0: core_read(addr, dm_model[addr >> 2]);
                1: begin
                    core_write(addr, data);
                    dm_model[addr >> 2] = data;
                    core_read(addr, expected);
                end
                2: begin
                    window_write(addr, data);
                    core_read(addr, expected);      // DM must not see it
                end
                3: fetch_check(addr, im_model[addr >> 2]);
                default: begin
                    $display("case %0d has an unknown kind %h", i, kind);
                    fail_run();
                end
            endcase
        end

        if (i_boot_loader.i_boot_fsm.i_boot_loader_assertions.error_count != 0) begin
            $display("a host handshake assertion failed during the run");
            fail_run();
        end else begin
            $display("All tests passed");
            $finish;
        end
    end

endmodule

/* testbench/boot_loader_assertions.sv */
module boot_loader_assertions (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 tx_done,
    input boot_pkg::host_op_t   host_op,
    input boot_pkg::host_addr_t host_addr,
    input boot_pkg::word_t      host_wrt_data,
    input logic                 core_stall
);
    import boot_pkg::*;

    int error_count = 0;    // failed checks so far

    // 2'b10 means nothing to the host
    a_no_unused_op: assert property (@(posedge clk) disable iff (!rst_n)
        host_op != host_unused)
        else begin
            $error("host_op carries the unused encoding");
            error_count++;
        end

    a_stall_on_read: assert property (@(posedge clk) disable iff (!rst_n)
        host_op == host_read |-> core_stall)
        else begin
            $error("core not stalled during a host read");
            error_count++;
        end

    // request held until the host ends it
    a_write_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (host_op == host_write && !tx_done) |=>
            (host_op == host_write && $stable(host_addr) && $stable(host_wrt_data)))
        else begin
            $error("host write request changed before tx_done");
            error_count++;
        end

endmodule

bind boot_fsm boot_loader_assertions i_boot_loader_assertions (
    .clk           (clk),
    .rst_n         (rst_n),
    .tx_done       (tx_done),
    .host_op       (host_op),
    .host_addr     (host_addr),
    .host_wrt_data (host_wrt_data),
    .core_stall    (core_stall)
);

/* rtl/boot_loader.sv */
module boot_loader (
    input  logic                 clk,
    input  logic                 rst_n,
    // host side
    input  logic                 ready,
    input  logic                 rd_valid,
    input  logic                 tx_done,
    input  boot_pkg::word_t      host_rd_data,
    output boot_pkg::host_op_t   host_op,
    output boot_pkg::host_addr_t host_addr,
    output boot_pkg::word_t      host_wrt_data,
    // core memory port
    input  boot_pkg::mem_addr_t  core_addr,
    input  boot_pkg::word_t      core_wrt_data,
    input  logic                 core_wrt_en,
    input  logic                 core_rd_en,
    output boot_pkg::word_t      core_rd_data,
    output logic                 core_stall,
    // fetch port
    input  boot_pkg::mem_addr_t  fetch_addr,
    output boot_pkg::word_t      fetch_instr
);

    block_ctl_if ctl_bus ();
    fill_if      fill_bus ();

    ////////////////////
    // control
    boot_fsm i_boot_fsm (
        .clk           (clk),
        .rst_n         (rst_n),
        .ready         (ready),
        .rd_valid      (rd_valid),
        .tx_done       (tx_done),
        .host_rd_data  (host_rd_data),
        .core_addr     (core_addr),
        .core_wrt_data (core_wrt_data),
        .core_wrt_en   (core_wrt_en),
        .host_op       (host_op),
        .host_addr     (host_addr),
        .host_wrt_data (host_wrt_data),
        .core_stall    (core_stall),
        .ctl           (ctl_bus.fsm),
        .fill          (fill_bus.fsm)
    );

    block_counter i_block_counter (
        .clk   (clk),
        .rst_n (rst_n),
        .ctl   (ctl_bus.counter)
    );

    ////////////////////
    // memories
    data_mem i_data_mem (
        .clk           (clk),
        .rst_n         (rst_n),
        .fill          (fill_bus.mem),
        .core_addr     (core_addr),
        .core_wrt_data (core_wrt_data),
        .core_wrt_en   (core_wrt_en),
        .core_rd_en    (core_rd_en),
        .core_stall    (core_stall),   // run mode gate for stores
        .core_rd_data  (core_rd_data)
    );

    instr_mem i_instr_mem (
        .clk         (clk),
        .fill        (fill_bus.mem),
        .fetch_addr  (fetch_addr),
        .fetch_instr (fetch_instr)
    );

endmodule

/* rtl/instr_mem.sv */
`include "boot_defines.svh"

module instr_mem (
    input  logic                clk,
    fill_if.mem                 fill,
    input  boot_pkg::mem_addr_t fetch_addr,
    output boot_pkg::word_t     fetch_instr
);
    import boot_pkg::*;

    localparam int AW = $clog2(`IM_DEPTH);

    word_t         mem [`IM_DEPTH];
    logic [AW-1:0] fill_idx;
    logic [AW-1:0] fetch_idx;

    assign fill_idx  = fill.addr[AW+1:2];
    assign fetch_idx = fetch_addr[AW+1:2];

    // loaded once during boot
    always_ff @(posedge clk) begin
        if (fill.im_wrt_en)
            mem[fill_idx] <= fill.wrt_data;
    end

    always_ff @(posedge clk) begin
        fetch_instr <= mem[fetch_idx];  // fetch runs every cycle
    end

endmodule

/* rtl/data_mem.sv */
`include "boot_defines.svh"

module data_mem (
    input  logic                clk,
    input  logic                rst_n,
    fill_if.mem                 fill,
    input  boot_pkg::mem_addr_t core_addr,
    input  boot_pkg::word_t     core_wrt_data,
    input  logic                core_wrt_en,
    input  logic                core_rd_en,
    input  logic                core_stall,
    output boot_pkg::word_t     core_rd_data
);
    import boot_pkg::*;

    localparam int AW = $clog2(`DM_DEPTH);

    word_t         mem [`DM_DEPTH];
    logic [AW-1:0] fill_idx;
    logic [AW-1:0] core_idx;
    logic          core_store;

    // byte address to word index
    assign fill_idx = fill.addr[AW+1:2];
    assign core_idx = core_addr[AW+1:2];

    // only in run mode, and never for the host window
    assign core_store = core_wrt_en && !core_stall && (core_addr < `HOST_WINDOW);

    always_ff @(posedge clk) begin
        if (fill.dm_wrt_en)
            mem[fill_idx] <= fill.wrt_data;
        else if (core_store)
            mem[core_idx] <= core_wrt_data;
    end

    ////////////////////
    // registered core read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            core_rd_data <= '0;
        else if (core_rd_en)
            core_rd_data <= mem[core_idx];
    end

endmodule

/* rtl/block_counter.sv */
`include "boot_defines.svh"

module block_counter (
    input  logic        clk,
    input  logic        rst_n,
    block_ctl_if.counter ctl
);
    import boot_pkg::*;

    localparam int        DM_IDX_W    = $clog2(`DM_BLOCKS);
    localparam int        IM_IDX_W    = $clog2(`IM_BLOCKS);
    localparam mem_addr_t BLOCK_BYTES = mem_addr_t'(`BLOCK_WORDS * 4);

    logic [DM_IDX_W-1:0] dm_idx;
    logic [IM_IDX_W-1:0] im_idx;
    logic                im_phase;  // set once all data blocks are in

    assign ctl.dm_last = (dm_idx == DM_IDX_W'(`DM_BLOCKS - 1));
    assign ctl.im_last = (im_idx == IM_IDX_W'(`IM_BLOCKS - 1));

    // data bases come from the table, instruction bases are evenly spaced
    assign ctl.block_base = im_phase ? mem_addr_t'(im_idx) * BLOCK_BYTES
                                     : dm_block_addr[dm_idx];

    ////////////////////
    // block indices
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dm_idx   <= '0;
            im_idx   <= '0;
            im_phase <= 1'b0;
        end else begin
            if (ctl.next_dm) begin
                if (ctl.dm_last)
                    im_phase <= 1'b1;
                else
                    dm_idx <= dm_idx + 1'b1;
            end
            if (ctl.next_im && !ctl.im_last)
                im_idx <= im_idx + 1'b1;
        end
    end

    // word 0 goes to the base directly, so the count starts one word in
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            ctl.word_addr <= '0;
        else if (ctl.set_addr)
            ctl.word_addr <= ctl.block_base + 16'd4;
        else if (ctl.inc_addr)
            ctl.word_addr <= ctl.word_addr + 16'd4;
    end

endmodule

/* rtl/boot_fsm.sv */
`include "boot_defines.svh"

module boot_fsm (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 ready,
    input  logic                 rd_valid,
    input  logic                 tx_done,
    input  boot_pkg::word_t      host_rd_data,
    input  boot_pkg::mem_addr_t  core_addr,
    input  boot_pkg::word_t      core_wrt_data,
    input  logic                 core_wrt_en,
    output boot_pkg::host_op_t   host_op,
    output boot_pkg::host_addr_t host_addr,
    output boot_pkg::word_t      host_wrt_data,
    output logic                 core_stall,
    block_ctl_if.fsm             ctl,
    fill_if.fsm                  fill
);
    import boot_pkg::*;

    boot_state_t state, next_state;
    host_addr_t  dm_host_addr;
    host_addr_t  im_host_addr;
    logic        window_wrt;

    // host side addresses for the current block
    assign dm_host_addr = {48'h0, ctl.block_base};
    assign im_host_addr = {47'h0, 1'b1, ctl.block_base};

    assign window_wrt = core_wrt_en && (core_addr >= `HOST_WINDOW);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            state <= st_idle;
        else
            state <= next_state;
    end

    ////////////////////
    // next state and outputs
    always_comb begin
        next_state    = state;
        host_op       = host_idle;
        host_addr     = '0;
        host_wrt_data = '0;
        core_stall    = 1'b1;   // core held off outside run mode
        ctl.set_addr  = 1'b0;
        ctl.inc_addr  = 1'b0;
        ctl.next_dm   = 1'b0;
        ctl.next_im   = 1'b0;
        fill.dm_wrt_en = 1'b0;
        fill.im_wrt_en = 1'b0;
        fill.addr      = ctl.word_addr;
        fill.wrt_data  = host_rd_data;

        case (state)
            st_idle: begin
                if (ready)
                    next_state = st_wait_dm;
            end
            st_wait_dm: begin
                host_op      = host_read;
                host_addr    = dm_host_addr;
                ctl.set_addr = 1'b1;
                if (rd_valid) begin
                    // word 0 lands at the block base
                    fill.dm_wrt_en = 1'b1;
                    fill.addr      = ctl.block_base;
                    next_state     = st_fill_dm;
                end
            end
            st_fill_dm: begin
                host_op        = host_read;
                host_addr      = dm_host_addr;
                fill.dm_wrt_en = 1'b1;
                ctl.inc_addr   = 1'b1;
                if (tx_done) begin
                    ctl.next_dm = 1'b1;
                    next_state  = ctl.dm_last ? st_wait_im : st_wait_dm;
                end
            end
            st_wait_im: begin
                host_op      = host_read;
                host_addr    = im_host_addr;
                ctl.set_addr = 1'b1;
                if (rd_valid) begin
                    fill.im_wrt_en = 1'b1;
                    fill.addr      = ctl.block_base;
                    next_state     = st_fill_im;
                end
            end
            st_fill_im: begin
                host_op        = host_read;
                host_addr      = im_host_addr;
                fill.im_wrt_en = 1'b1;
                ctl.inc_addr   = 1'b1;
                if (tx_done) begin
                    ctl.next_im = 1'b1;
                    next_state  = ctl.im_last ? st_run : st_wait_im;
                end
            end
            st_run: begin
                core_stall = 1'b0;
                if (window_wrt) begin
                    // first cycle of a forwarded write
                    core_stall    = 1'b1;
                    host_op       = host_write;
                    host_addr     = {48'h0, core_addr};
                    host_wrt_data = core_wrt_data;
                    next_state    = st_wrt_host;
                end
            end
            st_wrt_host: begin
                host_op       = host_write;
                host_addr     = {48'h0, core_addr};  // core holds its request
                host_wrt_data = core_wrt_data;
                core_stall    = !tx_done;            // released in the done cycle
                if (tx_done)
                    next_state = st_run;
            end
            default: next_state = st_idle;
        endcase
    end

endmodule

/* rtl/fill_if.sv */
interface fill_if;
    import boot_pkg::*;

    // boot time write port shared by both memories
    logic      dm_wrt_en;
    logic      im_wrt_en;
    mem_addr_t addr;        // byte address, word aligned
    word_t     wrt_data;

    modport fsm (
        output dm_wrt_en,
        output im_wrt_en,
        output addr,
        output wrt_data
    );

    modport mem (
        input dm_wrt_en,
        input im_wrt_en,
        input addr,
        input wrt_data
    );

endinterface

/* rtl/block_ctl_if.sv */
interface block_ctl_if;
    import boot_pkg::*;

    // requests from the boot FSM
    logic      set_addr;    // load word_addr from the block base
    logic      inc_addr;    // step to the next word
    logic      next_dm;     // data block finished
    logic      next_im;     // instruction block finished

    // state kept by the counter
    mem_addr_t block_base;
    mem_addr_t word_addr;
    logic      dm_last;
    logic      im_last;

    modport fsm (
        output set_addr, inc_addr, next_dm, next_im,
        input  block_base, word_addr, dm_last, im_last
    );

    modport counter (
        input  set_addr, inc_addr, next_dm, next_im,
        output block_base, word_addr, dm_last, im_last
    );

endinterface

/* rtl/boot_pkg.sv */
`include "boot_defines.svh"

package boot_pkg;

    // host transfer opcode, same encoding the host side decodes
    typedef enum logic [1:0] {
        host_idle   = 2'b00,
        host_read   = 2'b01,
        host_unused = 2'b10,
        host_write  = 2'b11
    } host_op_t;

    typedef enum logic [2:0] {
        st_idle,
        st_wait_dm,
        st_fill_dm,
        st_wait_im,
        st_fill_im,
        st_run,
        st_wrt_host
    } boot_state_t;

    typedef logic [15:0] mem_addr_t;    // byte address
    typedef logic [31:0] word_t;
    typedef logic [63:0] host_addr_t;   // bit 16 flags an instruction block

    // data block bases in host read order
    localparam mem_addr_t dm_block_addr [`DM_BLOCKS] = '{
        16'h1000, 16'h1040, 16'h1100, 16'h1140,
        16'h2000, 16'h2040, 16'h2100, 16'h2140,
        16'h3000, 16'h3040, 16'h3100, 16'h3140,
        16'h4000, 16'h4040, 16'h4100, 16'h4140,
        16'h0100
    };

endpackage

/* rtl/boot_defines.svh */
`ifndef BOOT_DEFINES_SVH
`define BOOT_DEFINES_SVH

// boot image layout
`define DM_BLOCKS    17     // data blocks read from host
`define IM_BLOCKS    48     // instruction blocks read from host
`define BLOCK_WORDS  16     // words per host transfer

// on-chip memory sizes, in 32-bit words
`define DM_DEPTH     16384
`define IM_DEPTH     1024

// core writes at or above this go out to the host
`define HOST_WINDOW  16'h9000

`endif
